// ==== include/id_remap_cfg.svh ====
// AXI ID remapper configuration: ID, address and data widths and the in-flight limits.
`ifndef ID_REMAP_CFG_SVH
`define ID_REMAP_CFG_SVH

// Width of the sparsely used ID space on the slave side.
`define ID_REMAP_SLV_ID_W 4

// Width of the dense ID space on the master side.
// It must be at least the width of the table index.
`define ID_REMAP_MST_ID_W 2

// Number of table entries per direction.
// This is the most distinct slave IDs that can be in flight at once.
`define ID_REMAP_MAX_UNIQ 4

// Most bursts in flight that may share one slave ID.
`define ID_REMAP_MAX_TXNS 3

// Address width, identical on both sides.
`define ID_REMAP_ADDR_W 16

// Data width, identical on both sides.
// The strobe carries one bit per byte of it.
`define ID_REMAP_DATA_W 32

`endif

// ==== verilog/id_remap_pkg.sv ====
// Shared types of the AXI ID remapper: IDs, table fields and the AXI channel structs.
`include "id_remap_cfg.svh"

package id_remap_pkg;

  // IDs as seen on the slave side and on the master side.
  typedef logic [`ID_REMAP_SLV_ID_W-1:0] slv_id_t;
  typedef logic [`ID_REMAP_MST_ID_W-1:0] mst_id_t;

  // Index into a remap table, which is also the low part of a master ID.
  typedef logic [$clog2(`ID_REMAP_MAX_UNIQ)-1:0] idx_t;

  // In-flight counter, wide enough to hold the per-ID limit itself.
  typedef logic [$clog2(`ID_REMAP_MAX_TXNS+1)-1:0] cnt_t;

  // One flag per table entry.
  typedef logic [`ID_REMAP_MAX_UNIQ-1:0] field_t;

  // A table entry ties a slave ID to the bursts still in flight under it.
  typedef struct packed {
    slv_id_t slv_id;
    cnt_t    cnt;
  } entry_t;

  // Address channel, used for both AR and AW.
  typedef struct packed {
    slv_id_t                  id;
    logic [`ID_REMAP_ADDR_W-1:0] addr;
    logic [7:0]               len;
  } slv_ax_t;

  typedef struct packed {
    mst_id_t                  id;
    logic [`ID_REMAP_ADDR_W-1:0] addr;
    logic [7:0]               len;
  } mst_ax_t;

  // Write data carries no ID, so one type serves both sides.
  typedef struct packed {
    logic [`ID_REMAP_DATA_W-1:0]   data;
    logic [`ID_REMAP_DATA_W/8-1:0] strb;
    logic                          last;
  } w_t;

  // Write response.
  typedef struct packed {
    slv_id_t    id;
    logic [1:0] resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t    id;
    logic [1:0] resp;
  } mst_b_t;

  // Read data.
  typedef struct packed {
    slv_id_t                     id;
    logic [`ID_REMAP_DATA_W-1:0] data;
    logic [1:0]                  resp;
    logic                        last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t                     id;
    logic [`ID_REMAP_DATA_W-1:0] data;
    logic [1:0]                  resp;
    logic                        last;
  } mst_r_t;

endpackage

// ==== verilog/first_set_finder.sv ====
// Priority encoder that returns the index of the lowest set bit and flags an all-zero field.
`timescale 1ns/1ps

module first_set_finder (
  input  id_remap_pkg::field_t bits_i,
  output id_remap_pkg::idx_t   idx_o,
  output logic                 empty_o
);

  // Scan from the top bit down, so the lowest set bit is the last one to win.
  always_comb begin
    idx_o = '0;
    for (int i = $bits(id_remap_pkg::field_t) - 1; i >= 0; i--) begin
      if (bits_i[i]) begin
        idx_o = id_remap_pkg::idx_t'(i);
      end
    end
  end

  // With no bit set the index stays at zero and must not be used.
  assign empty_o = ~|bits_i;

endmodule

// ==== verilog/id_remap_table.sv ====
// Remap table that maps slave IDs to dense indices and counts the bursts in flight per entry.
`timescale 1ns/1ps
`include "id_remap_cfg.svh"

module id_remap_table (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  id_remap_pkg::slv_id_t req_id_i,
  output logic                  accept_o,
  output id_remap_pkg::idx_t    assign_idx_o,
  input  logic                  push_i,
  input  logic                  pop_i,
  input  id_remap_pkg::idx_t    pop_idx_i,
  output id_remap_pkg::slv_id_t pop_inp_id_o
);

  // The table is indexed by the master-side index.
  id_remap_pkg::entry_t [`ID_REMAP_MAX_UNIQ-1:0] table_q;
  id_remap_pkg::entry_t [`ID_REMAP_MAX_UNIQ-1:0] table_d;

  id_remap_pkg::field_t free;
  id_remap_pkg::field_t match;
  id_remap_pkg::idx_t   free_idx;
  id_remap_pkg::idx_t   match_idx;
  logic                 full;
  logic                 no_match;
  logic                 match_room;

  // An entry is free exactly when none of its bursts are in flight.
  // A busy entry matches when it holds the requested slave ID.
  for (genvar i = 0; i < `ID_REMAP_MAX_UNIQ; i++) begin : gen_flags
    assign free[i]  = table_q[i].cnt == '0;
    assign match[i] = (table_q[i].cnt != '0) && (table_q[i].slv_id == req_id_i);
  end

  // Lowest free entry, used for a slave ID that is not yet in flight.
  first_set_finder free_finder (
    .bits_i  (free),
    .idx_o   (free_idx),
    .empty_o (full)
  );

  // Entry already holding the requested ID.
  // There is never more than one, so the lowest is the only one.
  first_set_finder match_finder (
    .bits_i  (match),
    .idx_o   (match_idx),
    .empty_o (no_match)
  );

  // A matching entry admits one more burst only below the per-ID limit.
  assign match_room = table_q[match_idx].cnt <
                      id_remap_pkg::cnt_t'(`ID_REMAP_MAX_TXNS);

  // Reusing the index keeps ordering of same-ID bursts on the master side.
  // A fresh ID takes a free entry so independent IDs stay independent.
  assign accept_o     = no_match ? !full : match_room;
  assign assign_idx_o = no_match ? free_idx : match_idx;

  // The slave ID for a response is read straight from the entry it points to.
  assign pop_inp_id_o = table_q[pop_idx_i].slv_id;

  // Push and pop may hit the same entry in one cycle and then cancel out.
  always_comb begin
    table_d = table_q;
    if (push_i) begin
      table_d[assign_idx_o].slv_id = req_id_i;
      table_d[assign_idx_o].cnt    = table_d[assign_idx_o].cnt + 1'b1;
    end
    if (pop_i) begin
      table_d[pop_idx_i].cnt = table_d[pop_idx_i].cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      table_q <= '0;
    end else begin
      table_q <= table_d;
    end
  end

  // The controller pushes on its own decision, so the push must agree with admission here.
  push_accepted_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> accept_o
  );

  // A response may only come back for a burst that was forwarded and is still counted.
  pop_busy_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> table_q[pop_idx_i].cnt != '0
  );

  // One slave ID never owns two entries, or ordering on the master side breaks.
  match_unique_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(match)
  );

endmodule

// ==== verilog/ax_id_assign.sv ====
// Address channel controller that forwards an admitted AR or AW and holds it under back-pressure.
`timescale 1ns/1ps

module ax_id_assign (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               slv_valid_i,
  output logic               slv_ready_o,
  output logic               mst_valid_o,
  input  logic               mst_ready_i,
  output id_remap_pkg::idx_t mst_idx_o,
  input  logic               accept_i,
  input  id_remap_pkg::idx_t assign_idx_i,
  output logic               push_o
);

  // Idle forwards new requests, hold keeps a forwarded one until the master side takes it.
  typedef enum logic {
    st_idle,
    st_hold
  } state_t;

  state_t             state_q;
  state_t             state_d;
  id_remap_pkg::idx_t idx_q;

  always_comb begin
    slv_ready_o = 1'b0;
    mst_valid_o = 1'b0;
    push_o      = 1'b0;
    mst_idx_o   = assign_idx_i;
    state_d     = state_q;
    case (state_q)
      st_idle: begin
        // The table has already checked the room for this ID.
        if (slv_valid_i && accept_i) begin
          mst_valid_o = 1'b1;
          push_o      = 1'b1;
          slv_ready_o = mst_ready_i;
          if (!mst_ready_i) begin
            state_d = st_hold;
          end
        end
      end
      st_hold: begin
        // The entry was counted on entry to this state, so no second push.
        // The table's index may move with pops, hence the registered copy.
        mst_valid_o = 1'b1;
        mst_idx_o   = idx_q;
        slv_ready_o = mst_ready_i;
        if (mst_ready_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the index while idle; it is only read after a stalled forward.
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle) begin
      idx_q <= assign_idx_i;
    end
  end

  // AXI demands that a raised valid and its ID stay until the handshake.
  hold_stable_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (mst_valid_o && !mst_ready_i) |=> mst_valid_o && $stable(mst_idx_o)
  );

endmodule

// ==== verilog/axi_id_remap.sv ====
// AXI ID remapper top level that packs sparse slave IDs into dense master IDs per direction.
`timescale 1ns/1ps

module axi_id_remap (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Slave side.
  input  id_remap_pkg::slv_ax_t slv_ar_i,
  input  logic                  slv_ar_valid_i,
  output logic                  slv_ar_ready_o,
  input  id_remap_pkg::slv_ax_t slv_aw_i,
  input  logic                  slv_aw_valid_i,
  output logic                  slv_aw_ready_o,
  input  id_remap_pkg::w_t      slv_w_i,
  input  logic                  slv_w_valid_i,
  output logic                  slv_w_ready_o,
  output id_remap_pkg::slv_b_t  slv_b_o,
  output logic                  slv_b_valid_o,
  input  logic                  slv_b_ready_i,
  output id_remap_pkg::slv_r_t  slv_r_o,
  output logic                  slv_r_valid_o,
  input  logic                  slv_r_ready_i,

  // Master side.
  output id_remap_pkg::mst_ax_t mst_ar_o,
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  output id_remap_pkg::mst_ax_t mst_aw_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output id_remap_pkg::w_t      mst_w_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  id_remap_pkg::mst_b_t  mst_b_i,
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o,
  input  id_remap_pkg::mst_r_t  mst_r_i,
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o
);

  logic                  rd_accept;
  logic                  rd_push;
  logic                  rd_pop;
  id_remap_pkg::idx_t    rd_assign_idx;
  id_remap_pkg::idx_t    rd_mst_idx;
  id_remap_pkg::slv_id_t rd_pop_id;

  logic                  wr_accept;
  logic                  wr_push;
  logic                  wr_pop;
  id_remap_pkg::idx_t    wr_assign_idx;
  id_remap_pkg::idx_t    wr_mst_idx;
  id_remap_pkg::slv_id_t wr_pop_id;

  // A read entry is released with the last beat of its burst, a write entry with its B.
  assign rd_pop = mst_r_valid_i && slv_r_ready_i && mst_r_i.last;
  assign wr_pop = mst_b_valid_i && slv_b_ready_i;

  // Read direction.
  id_remap_table rd_table (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_id_i     (slv_ar_i.id),
    .accept_o     (rd_accept),
    .assign_idx_o (rd_assign_idx),
    .push_i       (rd_push),
    .pop_i        (rd_pop),
    .pop_idx_i    (mst_r_i.id[$bits(id_remap_pkg::idx_t)-1:0]),
    .pop_inp_id_o (rd_pop_id)
  );

  ax_id_assign rd_assign (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .slv_valid_i  (slv_ar_valid_i),
    .slv_ready_o  (slv_ar_ready_o),
    .mst_valid_o  (mst_ar_valid_o),
    .mst_ready_i  (mst_ar_ready_i),
    .mst_idx_o    (rd_mst_idx),
    .accept_i     (rd_accept),
    .assign_idx_i (rd_assign_idx),
    .push_o       (rd_push)
  );

  // Write direction, independent of reads.
  id_remap_table wr_table (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_id_i     (slv_aw_i.id),
    .accept_o     (wr_accept),
    .assign_idx_o (wr_assign_idx),
    .push_i       (wr_push),
    .pop_i        (wr_pop),
    .pop_idx_i    (mst_b_i.id[$bits(id_remap_pkg::idx_t)-1:0]),
    .pop_inp_id_o (wr_pop_id)
  );

  ax_id_assign wr_assign (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .slv_valid_i  (slv_aw_valid_i),
    .slv_ready_o  (slv_aw_ready_o),
    .mst_valid_o  (mst_aw_valid_o),
    .mst_ready_i  (mst_aw_ready_i),
    .mst_idx_o    (wr_mst_idx),
    .accept_i     (wr_accept),
    .assign_idx_i (wr_assign_idx),
    .push_o       (wr_push)
  );

  // Address channels keep addr and len; the index is zero-extended into the master ID.
  assign mst_ar_o = '{id: id_remap_pkg::mst_id_t'(rd_mst_idx),
                     addr: slv_ar_i.addr,
                     len: slv_ar_i.len};
  assign mst_aw_o = '{id: id_remap_pkg::mst_id_t'(wr_mst_idx),
                     addr: slv_aw_i.addr,
                     len: slv_aw_i.len};

  // W carries no ID and passes through untouched.
  assign mst_w_o       = slv_w_i;
  assign mst_w_valid_o = slv_w_valid_i;
  assign slv_w_ready_o = mst_w_ready_i;

  // Responses get their slave ID back from the entry their master ID points to.
  assign slv_b_o       = '{id: wr_pop_id, resp: mst_b_i.resp};
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

  assign slv_r_o       = '{id: rd_pop_id,
                          data: mst_r_i.data,
                          resp: mst_r_i.resp,
                          last: mst_r_i.last};
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

endmodule

// ==== verif/axi_id_remap_tb.sv ====
// Directed testbench for the AXI ID remapper, checked against a model of both remap tables.
`timescale 1ns/1ps
`include "id_remap_cfg.svh"

module axi_id_remap_tb;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 5;
  // Longest wait for one address handshake before the run counts as hung.
  localparam int HS_LIMIT   = 20;
  localparam int RD         = 0;
  localparam int WR         = 1;

  logic                  clk_i;
  logic                  arst_n_i;
  id_remap_pkg::slv_ax_t slv_ar_i;
  logic                  slv_ar_valid_i;
  logic                  slv_ar_ready_o;
  id_remap_pkg::slv_ax_t slv_aw_i;
  logic                  slv_aw_valid_i;
  logic                  slv_aw_ready_o;
  id_remap_pkg::w_t      slv_w_i;
  logic                  slv_w_valid_i;
  logic                  slv_w_ready_o;
  id_remap_pkg::slv_b_t  slv_b_o;
  logic                  slv_b_valid_o;
  logic                  slv_b_ready_i;
  id_remap_pkg::slv_r_t  slv_r_o;
  logic                  slv_r_valid_o;
  logic                  slv_r_ready_i;
  id_remap_pkg::mst_ax_t mst_ar_o;
  logic                  mst_ar_valid_o;
  logic                  mst_ar_ready_i;
  id_remap_pkg::mst_ax_t mst_aw_o;
  logic                  mst_aw_valid_o;
  logic                  mst_aw_ready_i;
  id_remap_pkg::w_t      mst_w_o;
  logic                  mst_w_valid_o;
  logic                  mst_w_ready_i;
  id_remap_pkg::mst_b_t  mst_b_i;
  logic                  mst_b_valid_i;
  logic                  mst_b_ready_o;
  id_remap_pkg::mst_r_t  mst_r_i;
  logic                  mst_r_valid_i;
  logic                  mst_r_ready_o;

  // Reference tables, one row per direction, each entry a slave ID and a burst count.
  id_remap_pkg::slv_id_t model_id  [2][`ID_REMAP_MAX_UNIQ];
  int                    model_cnt [2][`ID_REMAP_MAX_UNIQ];

  axi_id_remap axi_id_remap_i (.*);

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic check_equal(input string test, input string what, input longint exp,
                             input longint act);
    assert (exp == act) else
      report_failure($sformatf("Mismatch in %s: %s expected 0x%0h actual 0x%0h",
                               test, what, exp, act));
  endtask

  // Reuse the entry that holds the ID, otherwise take the lowest free one.
  // A reused entry admits a burst only below the per-ID limit.
  function automatic void lookup_entry(input int dir, input id_remap_pkg::slv_id_t id,
                                       output logic acc, output id_remap_pkg::idx_t idx);
    logic found;
    found = 1'b0;
    acc   = 1'b0;
    idx   = '0;
    for (int i = 0; i < `ID_REMAP_MAX_UNIQ; i++) begin
      if (!found && model_cnt[dir][i] == 0) begin
        found = 1'b1;
        acc   = 1'b1;
        idx   = id_remap_pkg::idx_t'(i);
      end
    end
    for (int i = 0; i < `ID_REMAP_MAX_UNIQ; i++) begin
      if (model_cnt[dir][i] != 0 && model_id[dir][i] == id) begin
        acc = model_cnt[dir][i] < `ID_REMAP_MAX_TXNS;
        idx = id_remap_pkg::idx_t'(i);
      end
    end
  endfunction

  function automatic void push_entry(input int dir, input id_remap_pkg::slv_id_t id);
    logic               acc;
    id_remap_pkg::idx_t idx;
    lookup_entry(dir, id, acc, idx);
    model_id[dir][idx] = id;
    model_cnt[dir][idx]++;
  endfunction

  // Drive a new AR with a random address and length; valid stays up until the handshake.
  task automatic ar_drive(input id_remap_pkg::slv_id_t id);
    slv_ar_i.id    = id;
    slv_ar_i.addr  = `ID_REMAP_ADDR_W'($urandom());
    slv_ar_i.len   = 8'($urandom());
    slv_ar_valid_i = 1'b1;
  endtask

  // Wait for the slave-side AR handshake and check the forwarded request against the model.
  task automatic ar_complete(input string test, output id_remap_pkg::mst_id_t mst_id,
                             output int waited);
    logic               acc;
    id_remap_pkg::idx_t idx;
    waited = 0;
    #1;
    while (!slv_ar_ready_o) begin
      lookup_entry(RD, slv_ar_i.id, acc, idx);
      check_equal(test, "AR master valid", longint'(acc), longint'(mst_ar_valid_o));
      waited++;
      assert (waited < HS_LIMIT) else
        report_failure($sformatf("The AR handshake never happened in %s.", test));
      @(negedge clk_i);
      #1;
    end
    lookup_entry(RD, slv_ar_i.id, acc, idx);
    check_equal(test, "AR admission", longint'(acc), longint'(slv_ar_ready_o));
    check_equal(test, "AR master valid", 1, longint'(mst_ar_valid_o));
    check_equal(test, "AR master ID", longint'(idx), longint'(mst_ar_o.id));
    check_equal(test, "AR addr", longint'(slv_ar_i.addr), longint'(mst_ar_o.addr));
    check_equal(test, "AR len", longint'(slv_ar_i.len), longint'(mst_ar_o.len));
    mst_id = mst_ar_o.id;
    @(posedge clk_i);
    push_entry(RD, slv_ar_i.id);
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
  endtask

  task automatic ar_request(input string test, input id_remap_pkg::slv_id_t id,
                            input id_remap_pkg::mst_id_t exp_mst);
    id_remap_pkg::mst_id_t got;
    int                    waited;
    ar_drive(id);
    ar_complete(test, got, waited);
    check_equal(test, "AR expected master ID", longint'(exp_mst), longint'(got));
  endtask

  // A request without room sees no slave ready and is not forwarded.
  task automatic check_ar_stalled(input string test, input int cycles);
    repeat (cycles) begin
      #1;
      check_equal(test, "stalled AR slave ready", 0, longint'(slv_ar_ready_o));
      check_equal(test, "stalled AR master valid", 0, longint'(mst_ar_valid_o));
      @(negedge clk_i);
    end
  endtask

  // One R beat from the master side; the last beat releases the read entry.
  task automatic r_beat(input string test, input id_remap_pkg::mst_id_t mst_id,
                        input id_remap_pkg::slv_id_t exp_id, input logic last);
    mst_r_i.id    = mst_id;
    mst_r_i.data  = `ID_REMAP_DATA_W'($urandom());
    mst_r_i.resp  = 2'($urandom());
    mst_r_i.last  = last;
    mst_r_valid_i = 1'b1;
    #1;
    check_equal(test, "R valid", 1, longint'(slv_r_valid_o));
    check_equal(test, "R slave ID", longint'(exp_id), longint'(slv_r_o.id));
    check_equal(test, "R data", longint'(mst_r_i.data), longint'(slv_r_o.data));
    check_equal(test, "R resp", longint'(mst_r_i.resp), longint'(slv_r_o.resp));
    check_equal(test, "R last", longint'(last), longint'(slv_r_o.last));
    check_equal(test, "R master ready", 1, longint'(mst_r_ready_o));
    @(posedge clk_i);
    if (last) begin
      model_cnt[RD][mst_id]--;
    end
    @(negedge clk_i);
    mst_r_valid_i = 1'b0;
  endtask

  task automatic aw_request(input string test, input id_remap_pkg::slv_id_t id,
                            input id_remap_pkg::mst_id_t exp_mst);
    logic               acc;
    id_remap_pkg::idx_t idx;
    int                 waited;
    slv_aw_i.id    = id;
    slv_aw_i.addr  = `ID_REMAP_ADDR_W'($urandom());
    slv_aw_i.len   = 8'($urandom());
    slv_aw_valid_i = 1'b1;
    waited         = 0;
    #1;
    while (!slv_aw_ready_o) begin
      waited++;
      assert (waited < HS_LIMIT) else
        report_failure($sformatf("The AW handshake never happened in %s.", test));
      @(negedge clk_i);
      #1;
    end
    lookup_entry(WR, id, acc, idx);
    check_equal(test, "AW admission", longint'(acc), longint'(slv_aw_ready_o));
    check_equal(test, "AW master valid", 1, longint'(mst_aw_valid_o));
    check_equal(test, "AW master ID", longint'(idx), longint'(mst_aw_o.id));
    check_equal(test, "AW expected master ID", longint'(exp_mst), longint'(mst_aw_o.id));
    check_equal(test, "AW addr", longint'(slv_aw_i.addr), longint'(mst_aw_o.addr));
    check_equal(test, "AW len", longint'(slv_aw_i.len), longint'(mst_aw_o.len));
    @(posedge clk_i);
    push_entry(WR, id);
    @(negedge clk_i);
    slv_aw_valid_i = 1'b0;
  endtask

  // W has no ID, so the whole beat must come out unchanged.
  task automatic w_beat(input string test, input logic last);
    slv_w_i.data  = `ID_REMAP_DATA_W'($urandom());
    slv_w_i.strb  = 4'($urandom());
    slv_w_i.last  = last;
    slv_w_valid_i = 1'b1;
    #1;
    check_equal(test, "W beat", longint'(slv_w_i), longint'(mst_w_o));
    check_equal(test, "W master valid", 1, longint'(mst_w_valid_o));
    check_equal(test, "W slave ready", 1, longint'(slv_w_ready_o));
    @(posedge clk_i);
    @(negedge clk_i);
    slv_w_valid_i = 1'b0;
  endtask

  // Every B releases its write entry.
  task automatic b_response(input string test, input id_remap_pkg::mst_id_t mst_id,
                            input id_remap_pkg::slv_id_t exp_id);
    mst_b_i.id    = mst_id;
    mst_b_i.resp  = 2'($urandom());
    mst_b_valid_i = 1'b1;
    #1;
    check_equal(test, "B valid", 1, longint'(slv_b_valid_o));
    check_equal(test, "B slave ID", longint'(exp_id), longint'(slv_b_o.id));
    check_equal(test, "B resp", longint'(mst_b_i.resp), longint'(slv_b_o.resp));
    check_equal(test, "B master ready", 1, longint'(mst_b_ready_o));
    @(posedge clk_i);
    model_cnt[WR][mst_id]--;
    @(negedge clk_i);
    mst_b_valid_i = 1'b0;
  endtask

  task automatic fresh_id_reads();
    string t;
    t = "fresh_id_reads";
    ar_request(t, 4'd9, 2'd0);
    ar_request(t, 4'd5, 2'd1);
    ar_request(t, 4'd12, 2'd2);
    r_beat(t, 2'd1, 4'd5, 1'b1);
    r_beat(t, 2'd0, 4'd9, 1'b1);
    r_beat(t, 2'd2, 4'd12, 1'b1);
  endtask

  task automatic id_limit_stall();
    string                 t;
    id_remap_pkg::mst_id_t got;
    int                    waited;
    t = "id_limit_stall";
    repeat (3) ar_request(t, 4'd3, 2'd0);
    // The fourth burst of ID 3 waits until one of the three completes.
    ar_drive(4'd3);
    check_ar_stalled(t, 3);
    r_beat(t, 2'd0, 4'd3, 1'b1);
    ar_complete(t, got, waited);
    check_equal(t, "AR master ID after release", 0, longint'(got));
    repeat (3) r_beat(t, 2'd0, 4'd3, 1'b1);
  endtask

  task automatic table_full_reuse();
    string                 t;
    id_remap_pkg::mst_id_t got;
    int                    waited;
    t = "table_full_reuse";
    ar_request(t, 4'd1, 2'd0);
    ar_request(t, 4'd2, 2'd1);
    ar_request(t, 4'd4, 2'd2);
    ar_request(t, 4'd8, 2'd3);
    ar_drive(4'd6);
    check_ar_stalled(t, 2);
    // A beat without last keeps entry 1 busy.
    r_beat(t, 2'd1, 4'd2, 1'b0);
    check_ar_stalled(t, 2);
    r_beat(t, 2'd1, 4'd2, 1'b1);
    ar_complete(t, got, waited);
    check_equal(t, "AR master ID in freed entry", 1, longint'(got));
    r_beat(t, 2'd0, 4'd1, 1'b1);
    r_beat(t, 2'd1, 4'd6, 1'b1);
    r_beat(t, 2'd2, 4'd4, 1'b1);
    r_beat(t, 2'd3, 4'd8, 1'b1);
  endtask

  task automatic ar_back_pressure();
    string                 t;
    logic                  acc;
    id_remap_pkg::idx_t    idx;
    id_remap_pkg::mst_id_t got;
    int                    waited;
    t = "ar_back_pressure";
    mst_ar_ready_i = 1'b0;
    ar_drive(4'd7);
    lookup_entry(RD, 4'd7, acc, idx);
    // The forwarded AR must keep its valid and ID while the master side stalls.
    repeat (4) begin
      #1;
      check_equal(t, "held AR master valid", 1, longint'(mst_ar_valid_o));
      check_equal(t, "held AR master ID", longint'(idx), longint'(mst_ar_o.id));
      check_equal(t, "held AR slave ready", 0, longint'(slv_ar_ready_o));
      @(negedge clk_i);
    end
    mst_ar_ready_i = 1'b1;
    ar_complete(t, got, waited);
    check_equal(t, "cycles to handshake after ready", 0, longint'(waited));
    r_beat(t, got, 4'd7, 1'b1);
  endtask

  task automatic write_path();
    string t;
    t = "write_path";
    ar_request(t, 4'd4, 2'd0);
    ar_request(t, 4'd10, 2'd1);
    // ID 10 is in flight as a read at index 1, yet the write table is empty.
    aw_request(t, 4'd10, 2'd0);
    w_beat(t, 1'b0);
    w_beat(t, 1'b1);
    b_response(t, 2'd0, 4'd10);
    // A fresh ID landing on index 0 shows that the B freed the entry.
    aw_request(t, 4'd13, 2'd0);
    w_beat(t, 1'b1);
    b_response(t, 2'd0, 4'd13);
    r_beat(t, 2'd0, 4'd4, 1'b1);
    r_beat(t, 2'd1, 4'd10, 1'b1);
  endtask

  // The run is bounded by a budget of 200 clock cycles per test.
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    report_failure("The watchdog expired before the tests finished.");
  end

  initial begin
    void'($urandom(32'h4271));
    foreach (model_cnt[d, i]) begin
      model_cnt[d][i] = 0;
      model_id[d][i]  = '0;
    end
    arst_n_i       = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = 1'b1;
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // Out of reset nothing is forwarded and no request is acknowledged.
    #1;
    check_equal("reset", "AR master valid", 0, longint'(mst_ar_valid_o));
    check_equal("reset", "AW master valid", 0, longint'(mst_aw_valid_o));
    check_equal("reset", "AR slave ready", 0, longint'(slv_ar_ready_o));
    check_equal("reset", "AW slave ready", 0, longint'(slv_aw_ready_o));
    // Idle W, B and R channels pass their low valid and low ready straight through.
    check_equal("reset", "W master valid", 0, longint'(mst_w_valid_o));
    check_equal("reset", "B slave valid", 0, longint'(slv_b_valid_o));
    check_equal("reset", "R slave valid", 0, longint'(slv_r_valid_o));
    check_equal("reset", "W slave ready", 0, longint'(slv_w_ready_o));
    check_equal("reset", "B master ready", 0, longint'(mst_b_ready_o));
    check_equal("reset", "R master ready", 0, longint'(mst_r_ready_o));
    @(negedge clk_i);
    slv_b_ready_i = 1'b1;
    slv_r_ready_i = 1'b1;
    mst_w_ready_i = 1'b1;
    fresh_id_reads();
    id_limit_stall();
    table_full_reuse();
    ar_back_pressure();
    write_path();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
verilog/id_remap_pkg.sv
verilog/first_set_finder.sv
verilog/id_remap_table.sv
verilog/ax_id_assign.sv
verilog/axi_id_remap.sv
verif/axi_id_remap_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the AXI ID remapper testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module axi_id_remap_tb -f sim.f \
  -o axi_id_remap_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed."; exit 1; }
./obj_dir/axi_id_remap_sim > sim.log 2>&1
cat sim.log
grep -qx "TESTS PASSED" sim.log && echo "Simulation run succeeded." \
  || { echo "Simulation run did not succeed."; exit 1; }
